// ==== hdl/zorro_pkg.sv ====
package zorro_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  typedef logic [23:0] zorro_addr_t;
  typedef logic [15:0] bus_word_t;
  // byte address bits 20..1 cover 2 MB of 16-bit words
  typedef logic [19:0] ram_word_addr_t;
  // {upper, lower} byte lanes
  typedef logic [1:0]  byte_en_t;

  // address windows with an exclusive high bound
  localparam zorro_addr_t ram_low  = 24'h600000;
  localparam zorro_addr_t ram_high = 24'h740000;
  localparam zorro_addr_t cfg_low  = 24'he80000;
  localparam zorro_addr_t cfg_high = 24'he80100;

  localparam int wq_depth = 8;

  typedef logic [$clog2(wq_depth)-1:0]   wq_ptr_t;
  typedef logic [$clog2(wq_depth+1)-1:0] credit_t;

  typedef enum logic [1:0] {
    idle,
    cfg_read,
    ram_write,
    write_done
  } cycle_state_t;

  // identity nibbles come back in the top four data bits
  function automatic bus_word_t autoconfig_word(input logic [7:0] offset);
    logic [3:0] nib;
    case (offset)
      8'h00:   nib = 4'hc;   // zorro ii board
      8'h02:   nib = 4'h7;   // size
      8'h04:   nib = 4'h1;   // product
      8'h06:   nib = 4'h7;
      8'h08:   nib = 4'h4;   // flags
      8'h10:   nib = 4'h6;   // manufacturer
      8'h12:   nib = 4'hd;
      8'h14:   nib = 4'h6;
      8'h16:   nib = 4'hd;
      default: nib = 4'h0;
    endcase
    return {nib, 12'h000};
  endfunction

endpackage

// ==== hdl/wr_req_if.sv ====
`timescale 1ns/100ps

interface wr_req_if import zorro_pkg::*; ();

  // write request valid for one cycle per push
  logic           push;
  ram_word_addr_t word_addr;
  bus_word_t      data;
  byte_en_t       byte_en;
  // one pulse per entry that left the queue
  logic           credit_ret;

  modport producer (
    output push, word_addr, data, byte_en,
    input  credit_ret
  );

  modport consumer (
    input  push, word_addr, data, byte_en,
    output credit_ret
  );

endinterface

// ==== hdl/bus_sync.sv ====
`timescale 1ns/100ps

module bus_sync import zorro_pkg::*; (
  input  logic        vga_clk,
  input  logic        rst,
  input  logic        as_n,
  input  logic        uds_n,
  input  logic        lds_n,
  input  logic        read,
  input  zorro_addr_t za,
  input  bus_word_t   zd_in,
  output logic        as_n_s,
  output logic        read_s,
  output logic        uds_n_s,
  output logic        lds_n_s,
  output zorro_addr_t addr,
  output bus_word_t   data,
  output logic        strobe_stable
);

  logic [1:0] as_sync;
  logic [1:0] read_sync;
  logic [2:0] uds_sync;
  logic [2:0] lds_sync;

  // strobes idle high out of reset
  always_ff @(posedge vga_clk) begin
    if (rst) begin
      as_sync   <= '1;
      read_sync <= '1;
      uds_sync  <= '1;
      lds_sync  <= '1;
    end else begin
      as_sync   <= {as_sync[0], as_n};
      read_sync <= {read_sync[0], read};
      uds_sync  <= {uds_sync[1:0], uds_n};
      lds_sync  <= {lds_sync[1:0], lds_n};
    end
  end

  always_ff @(posedge vga_clk) begin
    addr <= za;
    data <= zd_in;
  end

  assign as_n_s  = as_sync[1];
  assign read_s  = read_sync[1];
  assign uds_n_s = uds_sync[2];
  assign lds_n_s = lds_sync[2];

  // last two stages agree and some lane is active
  assign strobe_stable = (uds_sync[2] == uds_sync[1]) && (lds_sync[2] == lds_sync[1])
                         && (!uds_sync[2] || !lds_sync[2]);

endmodule

// ==== hdl/bus_cycle_fsm.sv ====
`timescale 1ns/100ps

module bus_cycle_fsm import zorro_pkg::*; (
  input  logic        vga_clk,
  input  logic        rst,
  input  logic        cfgin_n,
  input  logic        as_n_s,
  input  logic        read_s,
  input  logic        uds_n_s,
  input  logic        lds_n_s,
  input  zorro_addr_t addr,
  input  bus_word_t   data,
  input  logic        strobe_stable,
  output logic        slave_n,
  output logic        dir,
  output logic        drive,
  output bus_word_t   rd_data,
  wr_req_if.producer  wr
);

  cycle_state_t state;
  logic         responding;
  credit_t      credits;
  logic         in_cfg;
  logic         in_ram;
  logic         issue;

  ////////////////////////////////////////////////////////////
  // window decode
  ////////////////////////////////////////////////////////////

  assign in_cfg = (addr >= cfg_low) && (addr < cfg_high);
  assign in_ram = (addr >= ram_low) && (addr < ram_high);

  // only write once the strobes settled and the queue has room
  assign issue = (state == ram_write) && strobe_stable && (credits != '0);

  ////////////////////////////////////////////////////////////
  // cycle state machine
  ////////////////////////////////////////////////////////////

  always_ff @(posedge vga_clk) begin
    if (rst) begin
      state      <= idle;
      responding <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (!as_n_s) begin
            if (read_s && in_cfg && !cfgin_n) begin
              state      <= cfg_read;
              responding <= 1'b1;
            end else if (!read_s && in_ram) begin
              state <= ram_write;
            end
          end
        end
        cfg_read: begin
          if (as_n_s) begin
            state      <= idle;
            responding <= 1'b0;
          end
        end
        ram_write: begin
          // host gave up before the strobes came
          if (as_n_s) begin
            state <= idle;
          end else if (issue) begin
            state <= write_done;
          end
        end
        write_done: begin
          if (as_n_s) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // table word follows the address until the read is decoded
  always_ff @(posedge vga_clk) begin
    if (state == idle) begin
      rd_data <= autoconfig_word(addr[7:0]);
    end
  end

  assign slave_n = ~responding;
  assign dir     = ~responding;
  assign drive   = responding;

  ////////////////////////////////////////////////////////////
  // write request and credits
  ////////////////////////////////////////////////////////////

  always_ff @(posedge vga_clk) begin
    if (rst) begin
      wr.push <= 1'b0;
    end else begin
      wr.push <= issue;
    end
  end

  always_ff @(posedge vga_clk) begin
    if (issue) begin
      wr.word_addr <= addr[20:1];
      wr.data      <= data;
      // uds is the upper lane
      wr.byte_en   <= {~uds_n_s, ~lds_n_s};
    end
  end

  always_ff @(posedge vga_clk) begin
    if (rst) begin
      credits <= credit_t'(wq_depth);
    end else begin
      credits <= credits - credit_t'(issue) + credit_t'(wr.credit_ret);
    end
  end

endmodule

// ==== hdl/write_queue.sv ====
`timescale 1ns/100ps

module write_queue import zorro_pkg::*; (
  input  logic           vga_clk,
  input  logic           rst,
  input  logic           mem_ready,
  output logic           mem_valid,
  output ram_word_addr_t mem_addr,
  output bus_word_t      mem_data,
  output byte_en_t       mem_byte_en,
  wr_req_if.consumer     wr
);

  ram_word_addr_t addr_q [wq_depth];
  bus_word_t      data_q [wq_depth];
  byte_en_t       be_q   [wq_depth];

  wq_ptr_t fill_ptr;
  wq_ptr_t drain_ptr;
  // entries still in the buffer and not yet in the command register
  credit_t count;
  logic    load;

  // refill the command register when it is empty or being taken
  assign load = (count != '0) && (!mem_valid || mem_ready);

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge vga_clk) begin
    if (wr.push) begin
      addr_q[fill_ptr] <= wr.word_addr;
      data_q[fill_ptr] <= wr.data;
      be_q[fill_ptr]   <= wr.byte_en;
    end
  end

  always_ff @(posedge vga_clk) begin
    if (rst) begin
      fill_ptr  <= '0;
      drain_ptr <= '0;
      count     <= '0;
    end else begin
      if (wr.push) begin
        fill_ptr <= fill_ptr + 1'b1;
      end
      if (load) begin
        drain_ptr <= drain_ptr + 1'b1;
      end
      count <= count + credit_t'(wr.push) - credit_t'(load);
    end
  end

  ////////////////////////////////////////////////////////////
  // memory command
  ////////////////////////////////////////////////////////////

  always_ff @(posedge vga_clk) begin
    if (rst) begin
      mem_valid     <= 1'b0;
      wr.credit_ret <= 1'b0;
    end else begin
      if (load) begin
        mem_valid <= 1'b1;
      end else if (mem_ready) begin
        mem_valid <= 1'b0;
      end
      // credit back one cycle after the transfer
      wr.credit_ret <= mem_valid && mem_ready;
    end
  end

  always_ff @(posedge vga_clk) begin
    if (load) begin
      mem_addr    <= addr_q[drain_ptr];
      mem_data    <= data_q[drain_ptr];
      mem_byte_en <= be_q[drain_ptr];
    end
  end

endmodule

// ==== hdl/zorro_ram_port.sv ====
`timescale 1ns/100ps

module zorro_ram_port import zorro_pkg::*; (
  input  logic           vga_clk,
  input  logic           rst,
  // zorro bus
  input  logic           cfgin_n,
  input  logic           as_n,
  input  logic           uds_n,
  input  logic           lds_n,
  input  logic           read,
  input  zorro_addr_t    za,
  inout  wire bus_word_t zd,
  output logic           slave_n,
  output logic           dir,
  // memory command port
  input  logic           mem_ready,
  output logic           mem_valid,
  output ram_word_addr_t mem_addr,
  output bus_word_t      mem_data,
  output byte_en_t       mem_byte_en
);

  logic        as_n_s;
  logic        read_s;
  logic        uds_n_s;
  logic        lds_n_s;
  zorro_addr_t addr;
  bus_word_t   data;
  logic        strobe_stable;
  logic        drive;
  bus_word_t   rd_data;

  wr_req_if wr ();

  bus_sync u_bus_sync (
    .vga_clk       (vga_clk),
    .rst           (rst),
    .as_n          (as_n),
    .uds_n         (uds_n),
    .lds_n         (lds_n),
    .read          (read),
    .za            (za),
    .zd_in         (zd),
    .as_n_s        (as_n_s),
    .read_s        (read_s),
    .uds_n_s       (uds_n_s),
    .lds_n_s       (lds_n_s),
    .addr          (addr),
    .data          (data),
    .strobe_stable (strobe_stable)
  );

  bus_cycle_fsm u_bus_cycle_fsm (
    .vga_clk       (vga_clk),
    .rst           (rst),
    .cfgin_n       (cfgin_n),
    .as_n_s        (as_n_s),
    .read_s        (read_s),
    .uds_n_s       (uds_n_s),
    .lds_n_s       (lds_n_s),
    .addr          (addr),
    .data          (data),
    .strobe_stable (strobe_stable),
    .slave_n       (slave_n),
    .dir           (dir),
    .drive         (drive),
    .rd_data       (rd_data),
    .wr            (wr.producer)
  );

  write_queue u_write_queue (
    .vga_clk     (vga_clk),
    .rst         (rst),
    .mem_ready   (mem_ready),
    .mem_valid   (mem_valid),
    .mem_addr    (mem_addr),
    .mem_data    (mem_data),
    .mem_byte_en (mem_byte_en),
    .wr          (wr.consumer)
  );

  // card drives the data bus only during an autoconfig reply
  assign zd = drive ? rd_data : 'z;

endmodule

// ==== include/tb_vectors.svh ====
// row fields in order is_read cfgin_n addr wdata uds_n lds_n hold_off resp stall rd_word
// a wdata of zero means the write word comes from $urandom
`ifndef tb_vectors_svh
`define tb_vectors_svh

typedef struct packed {
  logic        is_read;
  logic        cfgin_n;
  zorro_addr_t addr;
  bus_word_t   wdata;
  logic        uds_n;
  logic        lds_n;
  // cycles that mem_ready drops for from the start of this row
  logic [7:0]  hold_off;
  // slave_n low on a read or a memory command on a write
  logic        resp;
  // write must wait for a drained entry
  logic        stall;
  bus_word_t   rd_word;
} bus_row_t;

localparam int num_rows = 25;

localparam bus_row_t vectors [num_rows] = '{
  // autoconfig table
  '{1'b1, 1'b0, 24'he80000, 16'h0000, 1'b0, 1'b0, 8'd0, 1'b1, 1'b0, 16'hc000},
  '{1'b1, 1'b0, 24'he80002, 16'h0000, 1'b0, 1'b0, 8'd0, 1'b1, 1'b0, 16'h7000},
  '{1'b1, 1'b0, 24'he80004, 16'h0000, 1'b0, 1'b0, 8'd0, 1'b1, 1'b0, 16'h1000},
  '{1'b1, 1'b0, 24'he80006, 16'h0000, 1'b0, 1'b0, 8'd0, 1'b1, 1'b0, 16'h7000},
  '{1'b1, 1'b0, 24'he80008, 16'h0000, 1'b0, 1'b0, 8'd0, 1'b1, 1'b0, 16'h4000},
  '{1'b1, 1'b0, 24'he80010, 16'h0000, 1'b0, 1'b0, 8'd0, 1'b1, 1'b0, 16'h6000},
  '{1'b1, 1'b0, 24'he80012, 16'h0000, 1'b0, 1'b0, 8'd0, 1'b1, 1'b0, 16'hd000},
  '{1'b1, 1'b0, 24'he80014, 16'h0000, 1'b0, 1'b0, 8'd0, 1'b1, 1'b0, 16'h6000},
  '{1'b1, 1'b0, 24'he80016, 16'h0000, 1'b0, 1'b0, 8'd0, 1'b1, 1'b0, 16'hd000},
  '{1'b1, 1'b0, 24'he80040, 16'h0000, 1'b0, 1'b0, 8'd0, 1'b1, 1'b0, 16'h0000},
  // not for this card
  '{1'b1, 1'b1, 24'he80000, 16'h0000, 1'b0, 1'b0, 8'd0, 1'b0, 1'b0, 16'h0000},
  '{1'b1, 1'b0, 24'h100000, 16'h0000, 1'b0, 1'b0, 8'd0, 1'b0, 1'b0, 16'h0000},
  '{1'b0, 1'b1, 24'h200000, 16'h1234, 1'b0, 1'b0, 8'd0, 1'b0, 1'b0, 16'h0000},
  // byte lanes
  '{1'b0, 1'b1, 24'h600000, 16'h0000, 1'b0, 1'b1, 8'd0, 1'b1, 1'b0, 16'h0000},
  '{1'b0, 1'b1, 24'h6a5552, 16'h0000, 1'b1, 1'b0, 8'd0, 1'b1, 1'b0, 16'h0000},
  '{1'b0, 1'b1, 24'h73fffe, 16'hbeef, 1'b0, 1'b0, 8'd0, 1'b1, 1'b0, 16'h0000},
  // back-pressure with more writes than queue entries
  '{1'b0, 1'b1, 24'h601000, 16'h0000, 1'b0, 1'b0, 8'd200, 1'b1, 1'b0, 16'h0000},
  '{1'b0, 1'b1, 24'h601002, 16'h0000, 1'b0, 1'b1, 8'd0, 1'b1, 1'b0, 16'h0000},
  '{1'b0, 1'b1, 24'h601004, 16'h0000, 1'b1, 1'b0, 8'd0, 1'b1, 1'b0, 16'h0000},
  '{1'b0, 1'b1, 24'h601006, 16'h0000, 1'b0, 1'b0, 8'd0, 1'b1, 1'b0, 16'h0000},
  '{1'b0, 1'b1, 24'h620008, 16'h0000, 1'b0, 1'b0, 8'd0, 1'b1, 1'b0, 16'h0000},
  '{1'b0, 1'b1, 24'h62000a, 16'h0000, 1'b0, 1'b1, 8'd0, 1'b1, 1'b0, 16'h0000},
  '{1'b0, 1'b1, 24'h70000c, 16'h0000, 1'b1, 1'b0, 8'd0, 1'b1, 1'b0, 16'h0000},
  '{1'b0, 1'b1, 24'h70000e, 16'h0000, 1'b0, 1'b0, 8'd0, 1'b1, 1'b0, 16'h0000},
  '{1'b0, 1'b1, 24'h700010, 16'h0000, 1'b0, 1'b0, 8'd0, 1'b1, 1'b1, 16'h0000}
};

`endif

// ==== sim/tb_zorro_ram_port.sv ====
`timescale 1ns/100ps

module tb_zorro_ram_port import zorro_pkg::*; ();

  typedef struct packed {
    ram_word_addr_t addr;
    bus_word_t      data;
    byte_en_t       byte_en;
  } mem_cmd_t;

  localparam int resp_limit  = 8;
  localparam int push_limit  = 300;
  localparam int quiet_limit = 20;

  logic           vga_clk;
  logic           rst;
  logic           cfgin_n;
  logic           as_n;
  logic           uds_n;
  logic           lds_n;
  logic           read;
  zorro_addr_t    za;
  logic           mem_ready = 1'b1;
  logic           slave_n;
  logic           dir;
  logic           mem_valid;
  ram_word_addr_t mem_addr;
  bus_word_t      mem_data;
  byte_en_t       mem_byte_en;
  wire bus_word_t zd;
  bus_word_t      tb_zd;
  logic           tb_drive;

  int       cycle_cnt = 0;
  int       ready_at  = 0;
  int       xfer_cnt  = 0;
  int       errors    = 0;
  mem_cmd_t expect_q [$];
  mem_cmd_t exp_cmd;

  `include "tb_vectors.svh"

  zorro_ram_port u_dut (
    .vga_clk     (vga_clk),
    .rst         (rst),
    .cfgin_n     (cfgin_n),
    .as_n        (as_n),
    .uds_n       (uds_n),
    .lds_n       (lds_n),
    .read        (read),
    .za          (za),
    .zd          (zd),
    .slave_n     (slave_n),
    .dir         (dir),
    .mem_ready   (mem_ready),
    .mem_valid   (mem_valid),
    .mem_addr    (mem_addr),
    .mem_data    (mem_data),
    .mem_byte_en (mem_byte_en)
  );

  // host side of the data bus
  assign zd = tb_drive ? tb_zd : 'z;

  initial begin
    vga_clk = 1'b0;
    forever #2 vga_clk = ~vga_clk;
  end

  // memory controller stand-in that holds ready low until ready_at
  always @(posedge vga_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    mem_ready <= (cycle_cnt >= ready_at);
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  task automatic stop_on_error(input string line);
    errors++;
    $display("%s", line);
    $display("Checks failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_flag(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      stop_on_error($sformatf("Fail at %0t: %s is %b, expected %b", $time, what, actual,
                              expected));
    end
  endtask

  task automatic check_bus_word(input bus_word_t actual, input bus_word_t expected,
                                input string what);
    if (actual !== expected) begin
      stop_on_error($sformatf("Fail at %0t: %s is %h, expected %h", $time, what, actual,
                              expected));
    end
  endtask

  task automatic check_mem_cmd(input ram_word_addr_t addr, input bus_word_t data,
                               input byte_en_t be, input ram_word_addr_t exp_addr,
                               input bus_word_t exp_data, input byte_en_t exp_be);
    if (addr !== exp_addr || data !== exp_data || be !== exp_be) begin
      stop_on_error($sformatf("Fail at %0t: memory command %h %h %b, expected %h %h %b",
                              $time, addr, data, be, exp_addr, exp_data, exp_be));
    end
  endtask

  // every accepted command must match the oldest outstanding write
  always @(posedge vga_clk) begin
    if (!rst && mem_valid && mem_ready) begin
      if (expect_q.size() == 0) begin
        stop_on_error("Memory command appeared with no write outstanding");
      end else begin
        exp_cmd = expect_q.pop_front();
        check_mem_cmd(mem_addr, mem_data, mem_byte_en, exp_cmd.addr, exp_cmd.data,
                      exp_cmd.byte_en);
        xfer_cnt <= xfer_cnt + 1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // bus cycles
  ////////////////////////////////////////////////////////////

  task automatic run_read(input bus_row_t row);
    int n;
    cfgin_n <= row.cfgin_n;
    za      <= row.addr;
    read    <= 1'b1;
    as_n    <= 1'b0;
    uds_n   <= row.uds_n;
    lds_n   <= row.lds_n;
    if (row.resp) begin
      for (n = 0; n < resp_limit && slave_n !== 1'b0; n++) @(posedge vga_clk);
      if (slave_n !== 1'b0) stop_on_error("Timeout while waiting for slave_n to go low");
      check_flag(dir, 1'b0, "dir during autoconfig read");
      @(posedge vga_clk);
      check_flag(slave_n, 1'b0, "slave_n during autoconfig read");
      check_bus_word(zd, row.rd_word, $sformatf("autoconfig word at %h", row.addr));
    end else begin
      for (n = 0; n < quiet_limit; n++) begin
        @(posedge vga_clk);
        check_flag(slave_n, 1'b1, $sformatf("slave_n on foreign read at %h", row.addr));
      end
    end
    as_n  <= 1'b1;
    uds_n <= 1'b1;
    lds_n <= 1'b1;
    for (n = 0; n < resp_limit && slave_n !== 1'b1; n++) @(posedge vga_clk);
    if (slave_n !== 1'b1) stop_on_error("Timeout while waiting for slave_n to return high");
    check_flag(dir, 1'b1, "dir after read");
    check_flag(u_dut.drive, 1'b0, "data bus drive after read");
    repeat (4) @(posedge vga_clk);
  endtask

  task automatic run_write(input bus_row_t row);
    bus_word_t wd;
    mem_cmd_t  cmd;
    int        start_xfer;
    int        n;
    if (row.wdata == '0) begin
      wd = bus_word_t'($urandom);
    end else begin
      wd = row.wdata;
    end
    // command as the memory port must see it
    if (row.resp) begin
      cmd.addr = row.addr[20:1];
      cmd.data = wd;
      // upper strobe alone is lane 10, lower alone is 01, both are 11
      case ({row.uds_n, row.lds_n})
        2'b01:   cmd.byte_en = 2'b10;
        2'b10:   cmd.byte_en = 2'b01;
        default: cmd.byte_en = 2'b11;
      endcase
      expect_q.push_back(cmd);
    end
    start_xfer = xfer_cnt;
    cfgin_n  <= row.cfgin_n;
    za       <= row.addr;
    read     <= 1'b0;
    tb_zd    <= wd;
    tb_drive <= 1'b1;
    as_n     <= 1'b0;
    @(posedge vga_clk);
    uds_n <= row.uds_n;
    lds_n <= row.lds_n;
    if (row.resp) begin
      for (n = 0; n < push_limit && u_dut.wr.push !== 1'b1; n++) @(posedge vga_clk);
      if (u_dut.wr.push !== 1'b1) begin
        stop_on_error("Timeout while waiting for the card to take a RAM write");
      end
      if (row.stall) begin
        check_flag(xfer_cnt > start_xfer, 1'b1, "write held until a queue entry drained");
      end
    end else begin
      for (n = 0; n < quiet_limit; n++) begin
        @(posedge vga_clk);
        check_flag(u_dut.wr.push, 1'b0, $sformatf("write request at %h", row.addr));
      end
    end
    as_n     <= 1'b1;
    uds_n    <= 1'b1;
    lds_n    <= 1'b1;
    read     <= 1'b1;
    tb_drive <= 1'b0;
    repeat (4) @(posedge vga_clk);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int n;
    void'($urandom(59667));
    rst      = 1'b1;
    cfgin_n  = 1'b1;
    as_n     = 1'b1;
    uds_n    = 1'b1;
    lds_n    = 1'b1;
    read     = 1'b1;
    za       = '0;
    tb_zd    = '0;
    tb_drive = 1'b0;
    repeat (5) @(posedge vga_clk);
    rst <= 1'b0;
    @(posedge vga_clk);
    check_flag(slave_n, 1'b1, "slave_n after reset");
    check_flag(dir, 1'b1, "dir after reset");
    check_flag(u_dut.drive, 1'b0, "data bus drive after reset");
    check_flag(mem_valid, 1'b0, "mem_valid after reset");

    for (int i = 0; i < num_rows; i++) begin
      if (vectors[i].hold_off != '0) begin
        ready_at <= cycle_cnt + int'(vectors[i].hold_off);
      end
      if (vectors[i].is_read) begin
        run_read(vectors[i]);
      end else begin
        run_write(vectors[i]);
      end
    end

    for (n = 0; n < push_limit && (expect_q.size() != 0 || mem_valid); n++) begin
      @(posedge vga_clk);
    end
    if (expect_q.size() != 0 || mem_valid) begin
      stop_on_error("Timeout while waiting for the write queue to drain");
    end

    if (errors == 0 && expect_q.size() == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== zorro_ram_port.f ====
+incdir+include
hdl/zorro_pkg.sv
hdl/wr_req_if.sv
hdl/bus_sync.sv
hdl/bus_cycle_fsm.sv
hdl/write_queue.sv
hdl/zorro_ram_port.sv
sim/tb_zorro_ram_port.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with verilator, run it, then search the log for the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_zorro_ram_port -f zorro_ram_port.f \
  && ./obj_dir/Vtb_zorro_ram_port > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All checks passed" sim.log 2>/dev/null \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation did not pass"; exit 1; }
